// File: mtag_pkg.sv
// Memory tagging definitions
package mtag_pkg;

  // width of a source operand as seen by the function unit.
  localparam int XLEN = 32;

  // the tag sits in the top TLEN bits of a pointer.
  localparam int TLEN = 16;

  // only the low ADR_WIDTH operand bits address bytes in the tagged region.
  localparam int ADR_WIDTH = 9;

  // one tag covers a granule of this many bytes.
  localparam int GRANULARITY = 8;

  // number of byte address bits dropped to reach the granule index.
  localparam int GRAN_SHIFT = $clog2(GRANULARITY);

  // width of the tag memory address, one entry per granule.
  localparam int TADR_WIDTH = ADR_WIDTH - GRAN_SHIFT;

  // the tag memory holds one entry for every granule in the region.
  localparam int TAG_DEPTH = 2 ** TADR_WIDTH;

  // width of the saturating fault counter.
  localparam int FCNT_WIDTH = 8;

  // value at which the fault counter stops.
  localparam logic [FCNT_WIDTH-1:0] FCNT_MAX = {FCNT_WIDTH{1'b1}};

  // operations accepted by the tagging unit.
  // a set writes the pointer tag, a check compares against it.
  typedef enum logic {
    MTAG_OP_SET   = 1'b0,
    MTAG_OP_CHECK = 1'b1
  } mtag_op_e;

  // controller states.
  // ST_BUS covers the whole Wishbone cycle, however long ack takes.
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_BUS  = 2'd1,
    ST_DONE = 2'd2
  } mtag_state_e;

endpackage

// File: mtag_ctrl.sv
// Tagging unit controller
`timescale 1ns/100ps

module mtag_ctrl (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                ena_i,
  input  mtag_pkg::mtag_op_e  op_i,
  input  logic                tmem_ack_i,
  input  logic                mismatch_i,
  output logic                tmem_cyc_o,
  output logic                tmem_stb_o,
  output logic                rdy_o,
  output logic                err_o,
  output logic                record_o
);

  mtag_pkg::mtag_state_e state_q;
  mtag_pkg::mtag_state_e state_d;
  logic                  err_q;
  logic                  bus_done;

  // the bus cycle ends in the cycle where the tag memory acknowledges.
  assign bus_done = (state_q == mtag_pkg::ST_BUS) && tmem_ack_i;

  // next state logic.
  always_comb begin
    state_d = state_q;
    case (state_q)
      mtag_pkg::ST_IDLE: begin
        // a held enable is accepted only from idle.
        if (ena_i) begin
          state_d = mtag_pkg::ST_BUS;
        end
      end
      mtag_pkg::ST_BUS: begin
        // stay here as long as the slave holds off ack.
        if (tmem_ack_i) begin
          state_d = mtag_pkg::ST_DONE;
        end
      end
      mtag_pkg::ST_DONE: begin
        state_d = mtag_pkg::ST_IDLE;
      end
      default: begin
        state_d = mtag_pkg::ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= mtag_pkg::ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // the error flag is taken from the comparator on entry to ST_DONE.
  // it is cleared again on the next edge so it only lives beside rdy_o.
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      err_q <= 1'b0;
    end else if (bus_done) begin
      err_q <= mismatch_i;
    end else begin
      err_q <= 1'b0;
    end
  end

  // cyc and stb are held for the whole of ST_BUS, that is until ack.
  assign tmem_cyc_o = (state_q == mtag_pkg::ST_BUS);
  assign tmem_stb_o = (state_q == mtag_pkg::ST_BUS);

  // completion pulse, one cycle in ST_DONE.
  assign rdy_o = (state_q == mtag_pkg::ST_DONE);
  assign err_o = err_q;

  // the fault log samples on the same edge that moves us into ST_DONE.
  assign record_o = bus_done && (op_i == mtag_pkg::MTAG_OP_CHECK) && mismatch_i;

  // a strobe may only be raised inside an open bus cycle.
  assert property (@(posedge clk_i) disable iff (reset_i)
    $rose(tmem_stb_o) |-> tmem_cyc_o);

  // each request completes with a single-cycle ready.
  assert property (@(posedge clk_i) disable iff (reset_i)
    rdy_o |=> !rdy_o);

endmodule

// File: mtag_datapath.sv
// Tagging unit datapath
`timescale 1ns/100ps

module mtag_datapath (
  input  mtag_pkg::mtag_op_e               op_i,
  input  logic [mtag_pkg::XLEN-1:0]        src1_i,
  input  logic [mtag_pkg::TLEN-1:0]        tmem_dat_i,
  input  logic                             tmem_ack_i,
  output logic                             tmem_we_o,
  output logic                             tmem_sel_o,
  output logic [mtag_pkg::TADR_WIDTH-1:0]  tmem_adr_o,
  output logic [mtag_pkg::TLEN-1:0]        tmem_dat_o,
  output logic                             mismatch_o,
  output logic [mtag_pkg::ADR_WIDTH-1:0]   adr_o
);

  logic [mtag_pkg::TLEN-1:0]       ptr_tag;
  logic [mtag_pkg::ADR_WIDTH-1:0]  byte_adr;
  logic                            is_set;
  logic                            tag_differs;

  // the pointer tag is carried in the top bits of the operand.
  assign ptr_tag = src1_i[mtag_pkg::XLEN-1:mtag_pkg::XLEN-mtag_pkg::TLEN];

  // the byte address is the low part of the operand.
  // bits between the address and the tag are not looked at.
  assign byte_adr = src1_i[mtag_pkg::ADR_WIDTH-1:0];

  assign is_set = (op_i == mtag_pkg::MTAG_OP_SET);

  // the granule index drops the byte offset inside a granule.
  assign tmem_adr_o = byte_adr[mtag_pkg::ADR_WIDTH-1:mtag_pkg::GRAN_SHIFT];

  // the tag memory has a single lane, always selected during a request.
  // cyc and stb from the controller qualify the access.
  assign tmem_sel_o = 1'b1;

  // only a set writes.
  assign tmem_we_o = is_set;

  // write data is the pointer tag on a set and zero otherwise.
  always_comb begin
    if (is_set) begin
      tmem_dat_o = ptr_tag;
    end else begin
      tmem_dat_o = '0;
    end
  end

  // compare the stored tag with the pointer tag.
  assign tag_differs = (tmem_dat_i != ptr_tag);

  // read data is only valid in the ack cycle, so the result is masked
  // with ack; a set never reports a mismatch.
  assign mismatch_o = tmem_ack_i && !is_set && tag_differs;

  // full byte address for the fault log.
  assign adr_o = byte_adr;

endmodule

// File: tag_mem.sv
// Tag memory Wishbone slave
`timescale 1ns/100ps

module tag_mem (
  input  logic                             clk_i,
  input  logic                             reset_i,
  input  logic                             cyc_i,
  input  logic                             stb_i,
  input  logic                             we_i,
  input  logic                             sel_i,
  input  logic [mtag_pkg::TADR_WIDTH-1:0]  adr_i,
  input  logic [mtag_pkg::TLEN-1:0]        dat_i,
  output logic [mtag_pkg::TLEN-1:0]        dat_o,
  output logic                             ack_o
);

  logic [mtag_pkg::TLEN-1:0] tags_q [mtag_pkg::TAG_DEPTH];
  logic [mtag_pkg::TLEN-1:0] rdat_q;
  logic                      ack_q;
  logic                      access;

  // a new access is a strobe inside a cycle that has not been acked yet.
  // this keeps a held strobe from being served twice.
  assign access = cyc_i && stb_i && !ack_q;

  // one tag per granule; an untagged granule reads back as tag 0.
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < mtag_pkg::TAG_DEPTH; i++) begin
        tags_q[i] <= '0;
      end
    end else if (access && we_i && sel_i) begin
      // the write lands on the edge that raises ack.
      tags_q[adr_i] <= dat_i;
    end
  end

  // registered acknowledge, high for exactly one cycle per access.
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  // read data is captured with the ack so it is stable in the ack cycle.
  always_ff @(posedge clk_i) begin
    if (access) begin
      rdat_q <= tags_q[adr_i];
    end
  end

  assign dat_o = rdat_q;
  assign ack_o = ack_q;

  // the master must not drop cyc before the acknowledge has come.
  assert property (@(posedge clk_i) disable iff (reset_i)
    ack_o |-> cyc_i);

endmodule

// File: fault_log.sv
// Tag fault log
`timescale 1ns/100ps

module fault_log (
  input  logic                             clk_i,
  input  logic                             reset_i,
  input  logic                             record_i,
  input  logic [mtag_pkg::ADR_WIDTH-1:0]   adr_i,
  output logic [mtag_pkg::ADR_WIDTH-1:0]   fault_adr_o,
  output logic [mtag_pkg::FCNT_WIDTH-1:0]  fault_cnt_o
);

  logic [mtag_pkg::ADR_WIDTH-1:0]  fault_adr_q;
  logic [mtag_pkg::FCNT_WIDTH-1:0] fault_cnt_q;

  // the most recent violating byte address is kept until the next fault.
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      fault_adr_q <= '0;
    end else if (record_i) begin
      fault_adr_q <= adr_i;
    end
  end

  // fault counter, stops at its maximum so a long run of faults
  // never wraps back to a small value.
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      fault_cnt_q <= '0;
    end else if (record_i && (fault_cnt_q != mtag_pkg::FCNT_MAX)) begin
      fault_cnt_q <= fault_cnt_q + 1'b1;
    end
  end

  assign fault_adr_o = fault_adr_q;
  assign fault_cnt_o = fault_cnt_q;

endmodule

// File: mtag_top.sv
// Memory tagging unit top level
`timescale 1ns/100ps

module mtag_top (
  input  logic                             clk_i,
  input  logic                             reset_i,
  input  logic                             ena_i,
  input  mtag_pkg::mtag_op_e               op_i,
  input  logic [mtag_pkg::XLEN-1:0]        src1_i,
  output logic                             rdy_o,
  output logic                             err_o,
  output logic [mtag_pkg::ADR_WIDTH-1:0]   fault_adr_o,
  output logic [mtag_pkg::FCNT_WIDTH-1:0]  fault_cnt_o
);

  // Wishbone between the unit and its tag memory.
  logic                             tmem_cyc;
  logic                             tmem_stb;
  logic                             tmem_we;
  logic                             tmem_sel;
  logic [mtag_pkg::TADR_WIDTH-1:0]  tmem_adr;
  logic [mtag_pkg::TLEN-1:0]        tmem_dat_w;
  logic [mtag_pkg::TLEN-1:0]        tmem_dat_r;
  logic                             tmem_ack;

  // internal controls.
  logic                             mismatch;
  logic                             record;
  logic [mtag_pkg::ADR_WIDTH-1:0]   req_adr;

  // the controller sequences the request and owns cyc and stb.
  mtag_ctrl i_ctrl (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .ena_i      (ena_i),
    .op_i       (op_i),
    .tmem_ack_i (tmem_ack),
    .mismatch_i (mismatch),
    .tmem_cyc_o (tmem_cyc),
    .tmem_stb_o (tmem_stb),
    .rdy_o      (rdy_o),
    .err_o      (err_o),
    .record_o   (record)
  );

  // the datapath drives the rest of the master side and compares tags.
  mtag_datapath i_datapath (
    .op_i       (op_i),
    .src1_i     (src1_i),
    .tmem_dat_i (tmem_dat_r),
    .tmem_ack_i (tmem_ack),
    .tmem_we_o  (tmem_we),
    .tmem_sel_o (tmem_sel),
    .tmem_adr_o (tmem_adr),
    .tmem_dat_o (tmem_dat_w),
    .mismatch_o (mismatch),
    .adr_o      (req_adr)
  );

  tag_mem i_tag_mem (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .cyc_i   (tmem_cyc),
    .stb_i   (tmem_stb),
    .we_i    (tmem_we),
    .sel_i   (tmem_sel),
    .adr_i   (tmem_adr),
    .dat_i   (tmem_dat_w),
    .dat_o   (tmem_dat_r),
    .ack_o   (tmem_ack)
  );

  fault_log i_fault_log (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .record_i    (record),
    .adr_i       (req_adr),
    .fault_adr_o (fault_adr_o),
    .fault_cnt_o (fault_cnt_o)
  );

endmodule

// File: tb_mtag_top.sv
// Memory tagging unit testbench
`timescale 1ns/100ps

module tb_mtag_top;

  // cycles allowed between raising ena_i and seeing rdy_o.
  localparam int RDY_TIMEOUT = 20;

  logic                             clk_i;
  logic                             reset_i;
  logic                             ena_i;
  mtag_pkg::mtag_op_e               op_i;
  logic [mtag_pkg::XLEN-1:0]        src1_i;
  logic                             rdy_o;
  logic                             err_o;
  logic [mtag_pkg::ADR_WIDTH-1:0]   fault_adr_o;
  logic [mtag_pkg::FCNT_WIDTH-1:0]  fault_cnt_o;

  // reference state, one tag per granule plus the fault log contents.
  logic [mtag_pkg::TLEN-1:0]        shadow_tags [mtag_pkg::TAG_DEPTH];
  logic [mtag_pkg::ADR_WIDTH-1:0]   model_adr;
  logic [mtag_pkg::FCNT_WIDTH-1:0]  model_cnt;
  integer                           seed;
  int                               n_req;

  mtag_top i_dut (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .ena_i       (ena_i),
    .op_i        (op_i),
    .src1_i      (src1_i),
    .rdy_o       (rdy_o),
    .err_o       (err_o),
    .fault_adr_o (fault_adr_o),
    .fault_cnt_o (fault_cnt_o)
  );

  initial clk_i = 1'b0;
  always #50 clk_i = ~clk_i;

  task automatic check_err(input string name, input logic exp_val, input logic act_val);
    if (act_val !== exp_val) begin
      $display("Mismatch %s err: expected %0b, actual %0b", name, exp_val, act_val);
      $display("tests failed");
      $fatal(1, "wrong error flag");
    end
  endtask

  task automatic check_adr(input string name, input logic [mtag_pkg::ADR_WIDTH-1:0] exp_val,
                           input logic [mtag_pkg::ADR_WIDTH-1:0] act_val);
    if (act_val !== exp_val) begin
      $display("Mismatch %s fault_adr: expected %h, actual %h", name, exp_val, act_val);
      $display("tests failed");
      $fatal(1, "wrong fault address");
    end
  endtask

  task automatic check_cnt(input string name, input logic [mtag_pkg::FCNT_WIDTH-1:0] exp_val,
                           input logic [mtag_pkg::FCNT_WIDTH-1:0] act_val);
    if (act_val !== exp_val) begin
      $display("Mismatch %s fault_cnt: expected %h, actual %h", name, exp_val, act_val);
      $display("tests failed");
      $fatal(1, "wrong fault count");
    end
  endtask

  // applies the tagging rules to the reference state.
  // a set stores the pointer tag, a check that differs logs a fault.
  task automatic predict_request(input mtag_pkg::mtag_op_e req_op,
                                 input logic [mtag_pkg::XLEN-1:0] req_src,
                                 output logic exp_err);
    logic [mtag_pkg::TLEN-1:0]       tag;
    logic [mtag_pkg::ADR_WIDTH-1:0]  adr;
    logic [mtag_pkg::TADR_WIDTH-1:0] gran;
    tag  = req_src[mtag_pkg::XLEN-1 -: mtag_pkg::TLEN];
    adr  = req_src[mtag_pkg::ADR_WIDTH-1:0];
    gran = adr[mtag_pkg::ADR_WIDTH-1:mtag_pkg::GRAN_SHIFT];
    exp_err = 1'b0;
    if (req_op == mtag_pkg::MTAG_OP_SET) begin
      shadow_tags[gran] = tag;
    end else if (shadow_tags[gran] != tag) begin
      exp_err   = 1'b1;
      model_adr = adr;
      // the counter saturates at all ones.
      if (model_cnt != '1) begin
        model_cnt = model_cnt + 1'b1;
      end
    end
  endtask

  // drives one request on the falling edge and waits for its ready pulse.
  // the results are sampled at the falling edge inside the ready cycle.
  task automatic run_request(input string name, input mtag_pkg::mtag_op_e req_op,
                             input logic [mtag_pkg::XLEN-1:0] req_src,
                             output logic got_err,
                             output logic [mtag_pkg::ADR_WIDTH-1:0] got_adr,
                             output logic [mtag_pkg::FCNT_WIDTH-1:0] got_cnt);
    int   cycles;
    logic seen;
    ena_i  = 1'b1;
    op_i   = req_op;
    src1_i = req_src;
    seen   = 1'b0;
    cycles = 0;
    while (!seen && cycles < RDY_TIMEOUT) begin
      @(negedge clk_i);
      cycles++;
      if (rdy_o) begin
        seen = 1'b1;
      end
    end
    if (!seen) begin
      $display("request %s got no ready within %0d cycles", name, RDY_TIMEOUT);
      $display("tests failed");
      $fatal(1, "timeout waiting for ready");
    end
    got_err = err_o;
    got_adr = fault_adr_o;
    got_cnt = fault_cnt_o;
    // drop the enable so the next request starts from idle.
    ena_i = 1'b0;
    @(negedge clk_i);
    if (rdy_o) begin
      $display("request %s held ready high for more than one cycle", name);
      $display("tests failed");
      $fatal(1, "ready pulse too long");
    end
    n_req++;
  endtask

  initial begin
    int                              fd;
    int                              n;
    string                           line;
    string                           name;
    string                           op_word;
    mtag_pkg::mtag_op_e              req_op;
    logic [mtag_pkg::XLEN-1:0]       req_src;
    logic                            exp_err;
    logic [mtag_pkg::ADR_WIDTH-1:0]  exp_adr;
    logic [mtag_pkg::FCNT_WIDTH-1:0] exp_cnt;
    logic                            mdl_err;
    logic                            got_err;
    logic [mtag_pkg::ADR_WIDTH-1:0]  got_adr;
    logic [mtag_pkg::FCNT_WIDTH-1:0] got_cnt;
    logic [31:0]                     rnd;
    logic [mtag_pkg::TLEN-1:0]       tag;

    ena_i     = 1'b0;
    op_i      = mtag_pkg::MTAG_OP_SET;
    src1_i    = '0;
    reset_i   = 1'b1;
    seed      = 32'h554f_5214;
    n_req     = 0;
    model_adr = '0;
    model_cnt = '0;
    for (int i = 0; i < mtag_pkg::TAG_DEPTH; i++) begin
      shadow_tags[i] = '0;
    end

    repeat (8) @(negedge clk_i);
    reset_i = 1'b0;

    fd = $fopen("mtag_trace.txt", "r");
    if (fd == 0) begin
      $display("could not open the trace file mtag_trace.txt");
      $display("tests failed");
      $fatal(1, "missing trace");
    end

    // directed requests from the trace, comment lines start with a hash.
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n > 0 && line[0] != "#") begin
        n = $sscanf(line, "%s %s %h %h %h %h", name, op_word, req_src, exp_err, exp_adr,
                    exp_cnt);
        if (n == 6) begin
          if (op_word == "set") begin
            req_op = mtag_pkg::MTAG_OP_SET;
          end else if (op_word == "check") begin
            req_op = mtag_pkg::MTAG_OP_CHECK;
          end else begin
            $display("trace line %s has an unknown operation %s", name, op_word);
            $display("tests failed");
            $fatal(1, "bad trace operation");
          end
          predict_request(req_op, req_src, mdl_err);
          if (mdl_err !== exp_err || model_adr !== exp_adr || model_cnt !== exp_cnt) begin
            $display("trace line %s disagrees with the reference tag model", name);
            $display("tests failed");
            $fatal(1, "inconsistent trace");
          end
          run_request(name, req_op, req_src, got_err, got_adr, got_cnt);
          check_err(name, exp_err, got_err);
          check_adr(name, exp_adr, got_adr);
          check_cnt(name, exp_cnt, got_cnt);
        end else if (n > 0) begin
          $display("trace line could not be parsed: %s", line);
          $display("tests failed");
          $fatal(1, "bad trace line");
        end
      end
    end
    $fclose(fd);

    // random requests; half of the checks reuse the stored tag so both
    // outcomes are exercised.
    for (int k = 0; k < 10; k++) begin
      rnd = $random(seed);
      req_op = rnd[9] ? mtag_pkg::MTAG_OP_CHECK : mtag_pkg::MTAG_OP_SET;
      tag = rnd[mtag_pkg::XLEN-1 -: mtag_pkg::TLEN];
      if (rnd[9] && rnd[10]) begin
        tag = shadow_tags[rnd[mtag_pkg::ADR_WIDTH-1:mtag_pkg::GRAN_SHIFT]];
      end
      req_src = {tag, rnd[mtag_pkg::XLEN-mtag_pkg::TLEN-1:0]};
      name = $sformatf("random_%0d", k);
      predict_request(req_op, req_src, mdl_err);
      run_request(name, req_op, req_src, got_err, got_adr, got_cnt);
      check_err(name, mdl_err, got_err);
      check_adr(name, model_adr, got_adr);
      check_cnt(name, model_cnt, got_cnt);
    end

    if (n_req == 0) begin
      $display("no requests were run");
      $display("tests failed");
      $fatal(1, "empty run");
    end else begin
      $display("all tests passed");
      $finish;
    end
  end

endmodule

// File: mtag_top.f
mtag_pkg.sv
mtag_ctrl.sv
mtag_datapath.sv
tag_mem.sv
fault_log.sv
mtag_top.sv
tb_mtag_top.sv

// File: Makefile
# Verilator flow for the memory tagging unit.
VERILATOR  ?= verilator
FILELIST   ?= mtag_top.f
TB_TOP     ?= tb_mtag_top
RTL_TOP    ?= mtag_top
BUILD_DIR  ?= obj_dir
JOBS       ?= 0
VFLAGS     ?= --timing --assert
PASS_MSG   ?= all tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) --top-module $(TB_TOP) \
		-Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: mtag_trace.txt
# columns: name op src1 err fault_adr fault_cnt (src1, err, adr and cnt in hex)
# op is set or check; the expected values hold in the cycle where rdy_o is high
rst_chk_zero_a check 00000000 0 000 00
rst_chk_zero_b check 000001ff 0 000 00
rst_chk_tag_a check 12340040 1 040 01
rst_chk_tag_b check ffff01f8 1 1f8 02
set_g2 set abcd0010 0 1f8 02
chk_g2_b0 check abcd0010 0 1f8 02
chk_g2_b3 check abcd0013 0 1f8 02
chk_g2_b7 check abcd0017 0 1f8 02
chk_g3_next check abcd0018 1 018 03
chk_g2_wrong check abce0014 1 014 04
chk_g1_prev check abcd000f 1 00f 05
set_g3 set 55aa001c 0 00f 05
chk_g3_ok check 55aa0019 0 00f 05
chk_g2_still check abcd0011 0 00f 05
set_g2_new set 13570012 0 00f 05
chk_g2_old check abcd0010 1 010 06
chk_g2_new check 13570016 0 010 06
chk_g2_old_b7 check abcd0017 1 017 07
set_g63 set 7e5501f8 0 017 07
chk_g63_ok check 7e5501ff 0 017 07
chk_g62 check 7e5501f0 1 1f0 08
chk_mid_bits check 7e55fdf9 0 1f0 08
set_g0 set 0001fe00 0 1f0 08
chk_g0_zero check 00000004 1 004 09
chk_g0_ok check 00010007 0 004 09
set_g63_zero set 000001fa 0 004 09
chk_g63_old check 7e5501fc 1 1fc 0a
chk_g63_zero check 000001fe 0 1fc 0a
set_g31 set c0de00f8 0 1fc 0a
chk_g31_ok check c0de00ff 0 1fc 0a
chk_g32 check c0de0100 1 100 0b
chk_g30 check c0de00f7 1 0f7 0c
chk_rep_same check c0de0100 1 100 0d
chk_g2_final check 13570015 0 100 0d
set_g3_again set abcd001b 0 100 0d
chk_g3_new check abcd0018 0 100 0d
chk_g3_old check 55aa001f 1 01f 0e
chk_g3_new_b7 check abcd001f 0 01f 0e
